//--- logic/mem_addr_consts.svh
// Field widths and sizing constants for the memory address-space controller
// Included by the package and by every RTL file that declares loose fields

`ifndef MEM_ADDR_CONSTS_SVH
`define MEM_ADDR_CONSTS_SVH

// Message field widths
`define MEM_OPAQUE_NBITS 8
`define MEM_ADDR_NBITS 32
`define MEM_DATA_NBITS 32
`define MEM_LEN_NBITS 2

// Number of addressable bytes, anything at or above is denied
`define MEM_SIZE 32'd65536

// Partition register value after reset
`define INITIAL_PAR 32'hc000

`endif

//--- logic/mem_addr_pkg.sv
// Message types shared by the address-space controller blocks
// Request and response structs are only used inside the buffers and the FSM

`include "mem_addr_consts.svh"

package mem_addr_pkg;

	typedef enum logic {
		MEM_MSG_READ  = 1'b0,
		MEM_MSG_WRITE = 1'b1
	} mem_msg_type_e;

	// 76 bits
	typedef struct packed {
		mem_msg_type_e                msg_type;
		logic [`MEM_OPAQUE_NBITS-1:0] opaque;
		logic [`MEM_ADDR_NBITS-1:0]   addr;
		logic [`MEM_LEN_NBITS-1:0]    len;
		logic [`MEM_DATA_NBITS-1:0]   data;
		logic                         sec_level;
	} mem_req_msg_t;

	// 44 bits
	typedef struct packed {
		mem_msg_type_e                msg_type;
		logic [`MEM_OPAQUE_NBITS-1:0] opaque;
		logic [`MEM_LEN_NBITS-1:0]    len;
		logic [`MEM_DATA_NBITS-1:0]   data;
		logic                         sec_level;
	} mem_resp_msg_t;

endpackage

//--- logic/msg_hold_reg.sv
// One-entry valid/ready holding buffer, payload type set by parameter
// Used for both the request and the response side of the controller

`timescale 1ns/10ps

module msg_hold_reg
	import mem_addr_pkg::*;
#(
	parameter type msg_t = mem_req_msg_t
) (
	input  logic clk,
	input  logic reset,

	input  msg_t in_msg,
	input  logic in_val,
	output logic in_rdy,

	output msg_t out_msg,
	output logic out_val,
	input  logic out_rdy
);

	logic full;

	// Accept when empty, or when the held entry leaves this cycle
	assign in_rdy  = !full || out_rdy;
	assign out_val = full;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (in_val && in_rdy) begin
			full <= 1'b1;
		end else if (out_rdy) begin
			full <= 1'b0;
		end
	end

	// Payload register
	always_ff @(posedge clk) begin
		if (in_val && in_rdy) begin
			out_msg <= in_msg;
		end
	end

endmodule

//--- logic/cache_req_in.sv
// Request side of the controller
// Packs the loose cache request fields and holds one request for the FSM

`timescale 1ns/10ps

`include "mem_addr_consts.svh"

module cache_req_in
	import mem_addr_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,

	// Cache request
	input  logic                         cache_req_type,
	input  logic [`MEM_OPAQUE_NBITS-1:0] cache_req_opaque,
	input  logic [`MEM_ADDR_NBITS-1:0]   cache_req_addr,
	input  logic [`MEM_LEN_NBITS-1:0]    cache_req_len,
	input  logic [`MEM_DATA_NBITS-1:0]   cache_req_data,
	input  logic                         req_sec_level,
	input  logic                         cache_req_val,
	output logic                         cache_req_rdy,

	// Held request towards the FSM
	output mem_req_msg_t                 held_req,
	output logic                         held_req_val,
	input  logic                         held_req_rdy
);

	mem_req_msg_t req_packed;

	always_comb begin
		req_packed.msg_type  = mem_msg_type_e'(cache_req_type);
		req_packed.opaque    = cache_req_opaque;
		req_packed.addr      = cache_req_addr;
		req_packed.len       = cache_req_len;
		req_packed.data      = cache_req_data;
		req_packed.sec_level = req_sec_level;
	end

	msg_hold_reg #(
		.msg_t (mem_req_msg_t)
	) req_buf (
		.clk     (clk),
		.reset   (reset),
		.in_msg  (req_packed),
		.in_val  (cache_req_val),
		.in_rdy  (cache_req_rdy),
		.out_msg (held_req),
		.out_val (held_req_val),
		.out_rdy (held_req_rdy)
	);

endmodule

//--- logic/addr_space_ctrl.sv
// Access control FSM with the partition register
// Checks each held request, forwards it to memory or answers it locally

`timescale 1ns/10ps

`include "mem_addr_consts.svh"

module addr_space_ctrl
	import mem_addr_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,

	// Held request
	input  mem_req_msg_t                 held_req,
	input  logic                         held_req_val,
	output logic                         held_req_rdy,

	// Memory request port
	output logic                         mem_req_type,
	output logic [`MEM_OPAQUE_NBITS-1:0] mem_req_opaque,
	output logic [`MEM_ADDR_NBITS-1:0]   mem_req_addr,
	output logic [`MEM_LEN_NBITS-1:0]    mem_req_len,
	output logic [`MEM_DATA_NBITS-1:0]   mem_req_data,
	output logic                         mem_req_domain,
	output logic                         mem_req_val,
	input  logic                         mem_req_rdy,

	// Local response, data is always zero
	output logic                         local_resp_val,
	input  logic                         local_resp_rdy,
	output logic                         local_resp_type,
	output logic [`MEM_OPAQUE_NBITS-1:0] local_resp_opaque,
	output logic [`MEM_LEN_NBITS-1:0]    local_resp_len,
	output logic                         local_resp_sec,

	// Memory response tracking
	output logic                         fwd_pending,
	input  logic                         fwd_done,

	output logic                         insecure
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CHECK,
		ST_MEM_REQ,
		ST_MEM_WAIT,
		ST_LOCAL_RESP
	} ctrl_state_e;

	ctrl_state_e state;
	ctrl_state_e state_next;

	mem_req_msg_t               req_r;
	logic [`MEM_ADDR_NBITS-1:0] par_reg;

	logic out_of_range;
	logic par_write;
	logic deny;

	// ----------------------------------------
	// Security and range check
	// ----------------------------------------

	always_comb begin
		out_of_range = req_r.addr >= `MEM_SIZE;
		par_write    = 1'b0;
		deny         = 1'b0;
		if (out_of_range) begin
			deny = 1'b1;
		end else if (req_r.sec_level) begin
			// Secure write to 0 retargets the partition
			par_write = (req_r.msg_type == MEM_MSG_WRITE) && (req_r.addr == '0);
		end else begin
			deny = (req_r.addr == '0) || (req_r.addr >= par_reg);
		end
	end

	// ----------------------------------------
	// State machine
	// ----------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (held_req_val) begin
					state_next = ST_CHECK;
				end
			end
			ST_CHECK: begin
				if (deny || par_write) begin
					state_next = ST_LOCAL_RESP;
				end else begin
					state_next = ST_MEM_REQ;
				end
			end
			ST_MEM_REQ: begin
				if (mem_req_rdy) begin
					state_next = ST_MEM_WAIT;
				end
			end
			ST_MEM_WAIT: begin
				if (fwd_done) begin
					state_next = ST_IDLE;
				end
			end
			ST_LOCAL_RESP: begin
				if (local_resp_rdy) begin
					state_next = ST_IDLE;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Request register, loaded when the FSM takes a request
	always_ff @(posedge clk) begin
		if (held_req_val && held_req_rdy) begin
			req_r <= held_req;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			par_reg <= `INITIAL_PAR;
		end else if (state == ST_CHECK && par_write) begin
			par_reg <= req_r.data;
		end
	end

	// One-cycle pulse on the first local response cycle of a denial
	always_ff @(posedge clk) begin
		if (reset) begin
			insecure <= 1'b0;
		end else begin
			insecure <= (state == ST_CHECK) && deny;
		end
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------

	assign held_req_rdy = (state == ST_IDLE);

	assign mem_req_val    = (state == ST_MEM_REQ);
	assign mem_req_type   = req_r.msg_type;
	assign mem_req_opaque = req_r.opaque;
	assign mem_req_addr   = req_r.addr;
	assign mem_req_len    = req_r.len;
	assign mem_req_data   = req_r.data;
	assign mem_req_domain = req_r.sec_level;

	assign fwd_pending = (state == ST_MEM_WAIT);

	assign local_resp_val    = (state == ST_LOCAL_RESP);
	assign local_resp_type   = req_r.msg_type;
	assign local_resp_opaque = req_r.opaque;
	assign local_resp_len    = req_r.len;
	assign local_resp_sec    = req_r.sec_level;

endmodule

//--- logic/resp_merge.sv
// Response side of the controller
// Picks the memory or the local response, buffers it and drives the cache

`timescale 1ns/10ps

`include "mem_addr_consts.svh"

module resp_merge
	import mem_addr_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,

	// Memory response
	input  logic                         mem_resp_type,
	input  logic [`MEM_OPAQUE_NBITS-1:0] mem_resp_opaque,
	input  logic [`MEM_LEN_NBITS-1:0]    mem_resp_len,
	input  logic [`MEM_DATA_NBITS-1:0]   mem_resp_data,
	input  logic                         mem_resp_val,
	output logic                         mem_resp_rdy,

	// Forward tracking from the FSM
	input  logic                         fwd_pending,
	output logic                         fwd_done,
	input  logic                         mem_req_domain,

	// Local response
	input  logic                         local_resp_val,
	output logic                         local_resp_rdy,
	input  logic                         local_resp_type,
	input  logic [`MEM_OPAQUE_NBITS-1:0] local_resp_opaque,
	input  logic [`MEM_LEN_NBITS-1:0]    local_resp_len,
	input  logic                         local_resp_sec,

	// Cache response
	output logic                         cache_resp_type,
	output logic [`MEM_OPAQUE_NBITS-1:0] cache_resp_opaque,
	output logic [`MEM_LEN_NBITS-1:0]    cache_resp_len,
	output logic [`MEM_DATA_NBITS-1:0]   cache_resp_data,
	output logic                         resp_sec_level,
	output logic                         cache_resp_val,
	input  logic                         cache_resp_rdy
);

	mem_resp_msg_t merged;
	mem_resp_msg_t resp_q;
	logic          merged_val;
	logic          buf_in_rdy;

	// Memory path only while a forward is outstanding
	always_comb begin
		if (fwd_pending) begin
			merged.msg_type  = mem_msg_type_e'(mem_resp_type);
			merged.opaque    = mem_resp_opaque;
			merged.len       = mem_resp_len;
			merged.data      = mem_resp_data;
			merged.sec_level = mem_req_domain;
			merged_val       = mem_resp_val;
		end else begin
			merged.msg_type  = mem_msg_type_e'(local_resp_type);
			merged.opaque    = local_resp_opaque;
			merged.len       = local_resp_len;
			merged.data      = '0;
			merged.sec_level = local_resp_sec;
			merged_val       = local_resp_val;
		end
	end

	assign mem_resp_rdy   = fwd_pending && buf_in_rdy;
	assign local_resp_rdy = !fwd_pending && buf_in_rdy;
	assign fwd_done       = mem_resp_val && mem_resp_rdy;

	msg_hold_reg #(
		.msg_t (mem_resp_msg_t)
	) resp_buf (
		.clk     (clk),
		.reset   (reset),
		.in_msg  (merged),
		.in_val  (merged_val),
		.in_rdy  (buf_in_rdy),
		.out_msg (resp_q),
		.out_val (cache_resp_val),
		.out_rdy (cache_resp_rdy)
	);

	// Unpack to loose cache fields
	assign cache_resp_type   = resp_q.msg_type;
	assign cache_resp_opaque = resp_q.opaque;
	assign cache_resp_len    = resp_q.len;
	assign cache_resp_data   = resp_q.data;
	assign resp_sec_level    = resp_q.sec_level;

endmodule

//--- logic/mem_addr_ctrl_top.sv
// Top level of the memory address-space controller
// Sits between cache request/response ports and main memory

`timescale 1ns/10ps

`include "mem_addr_consts.svh"

module mem_addr_ctrl_top (
	input  logic                         clk,
	input  logic                         reset,

	// Cache request in
	input  logic                         cache_req_type,
	input  logic [`MEM_OPAQUE_NBITS-1:0] cache_req_opaque,
	input  logic [`MEM_ADDR_NBITS-1:0]   cache_req_addr,
	input  logic [`MEM_LEN_NBITS-1:0]    cache_req_len,
	input  logic [`MEM_DATA_NBITS-1:0]   cache_req_data,
	input  logic                         req_sec_level,
	input  logic                         cache_req_val,
	output logic                         cache_req_rdy,

	// Memory request out
	output logic                         mem_req_type,
	output logic [`MEM_OPAQUE_NBITS-1:0] mem_req_opaque,
	output logic [`MEM_ADDR_NBITS-1:0]   mem_req_addr,
	output logic [`MEM_LEN_NBITS-1:0]    mem_req_len,
	output logic [`MEM_DATA_NBITS-1:0]   mem_req_data,
	output logic                         mem_req_domain,
	output logic                         mem_req_val,
	input  logic                         mem_req_rdy,

	// Memory response in
	input  logic                         mem_resp_type,
	input  logic [`MEM_OPAQUE_NBITS-1:0] mem_resp_opaque,
	input  logic [`MEM_LEN_NBITS-1:0]    mem_resp_len,
	input  logic [`MEM_DATA_NBITS-1:0]   mem_resp_data,
	input  logic                         mem_resp_val,
	output logic                         mem_resp_rdy,

	// Cache response out
	output logic                         cache_resp_type,
	output logic [`MEM_OPAQUE_NBITS-1:0] cache_resp_opaque,
	output logic [`MEM_LEN_NBITS-1:0]    cache_resp_len,
	output logic [`MEM_DATA_NBITS-1:0]   cache_resp_data,
	output logic                         resp_sec_level,
	output logic                         cache_resp_val,
	input  logic                         cache_resp_rdy,

	output logic                         insecure
);

	mem_addr_pkg::mem_req_msg_t   held_req;
	logic                         held_req_val;
	logic                         held_req_rdy;

	logic                         local_resp_val;
	logic                         local_resp_rdy;
	logic                         local_resp_type;
	logic [`MEM_OPAQUE_NBITS-1:0] local_resp_opaque;
	logic [`MEM_LEN_NBITS-1:0]    local_resp_len;
	logic                         local_resp_sec;

	logic                         fwd_pending;
	logic                         fwd_done;

	cache_req_in req_in (
		.clk              (clk),
		.reset            (reset),
		.cache_req_type   (cache_req_type),
		.cache_req_opaque (cache_req_opaque),
		.cache_req_addr   (cache_req_addr),
		.cache_req_len    (cache_req_len),
		.cache_req_data   (cache_req_data),
		.req_sec_level    (req_sec_level),
		.cache_req_val    (cache_req_val),
		.cache_req_rdy    (cache_req_rdy),
		.held_req         (held_req),
		.held_req_val     (held_req_val),
		.held_req_rdy     (held_req_rdy)
	);

	addr_space_ctrl ctrl (
		.clk               (clk),
		.reset             (reset),
		.held_req          (held_req),
		.held_req_val      (held_req_val),
		.held_req_rdy      (held_req_rdy),
		.mem_req_type      (mem_req_type),
		.mem_req_opaque    (mem_req_opaque),
		.mem_req_addr      (mem_req_addr),
		.mem_req_len       (mem_req_len),
		.mem_req_data      (mem_req_data),
		.mem_req_domain    (mem_req_domain),
		.mem_req_val       (mem_req_val),
		.mem_req_rdy       (mem_req_rdy),
		.local_resp_val    (local_resp_val),
		.local_resp_rdy    (local_resp_rdy),
		.local_resp_type   (local_resp_type),
		.local_resp_opaque (local_resp_opaque),
		.local_resp_len    (local_resp_len),
		.local_resp_sec    (local_resp_sec),
		.fwd_pending       (fwd_pending),
		.fwd_done          (fwd_done),
		.insecure          (insecure)
	);

	resp_merge merge (
		.clk               (clk),
		.reset             (reset),
		.mem_resp_type     (mem_resp_type),
		.mem_resp_opaque   (mem_resp_opaque),
		.mem_resp_len      (mem_resp_len),
		.mem_resp_data     (mem_resp_data),
		.mem_resp_val      (mem_resp_val),
		.mem_resp_rdy      (mem_resp_rdy),
		.fwd_pending       (fwd_pending),
		.fwd_done          (fwd_done),
		.mem_req_domain    (mem_req_domain),
		.local_resp_val    (local_resp_val),
		.local_resp_rdy    (local_resp_rdy),
		.local_resp_type   (local_resp_type),
		.local_resp_opaque (local_resp_opaque),
		.local_resp_len    (local_resp_len),
		.local_resp_sec    (local_resp_sec),
		.cache_resp_type   (cache_resp_type),
		.cache_resp_opaque (cache_resp_opaque),
		.cache_resp_len    (cache_resp_len),
		.cache_resp_data   (cache_resp_data),
		.resp_sec_level    (resp_sec_level),
		.cache_resp_val    (cache_resp_val),
		.cache_resp_rdy    (cache_resp_rdy)
	);

endmodule

//--- sim/tb_clock.sv
// Testbench clock and reset source
// 8 ns clock, reset held for four cycles and released on a falling edge

`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- sim/mem_addr_props.sv
// Concurrent checks on the controller's memory request port and status pulse
// Bound into every addr_space_ctrl instance

`timescale 1ns/10ps

`include "mem_addr_consts.svh"

module mem_addr_props (
	input logic                         clk,
	input logic                         reset,
	input logic                         mem_req_val,
	input logic                         mem_req_rdy,
	input logic                         mem_req_type,
	input logic [`MEM_OPAQUE_NBITS-1:0] mem_req_opaque,
	input logic [`MEM_ADDR_NBITS-1:0]   mem_req_addr,
	input logic [`MEM_LEN_NBITS-1:0]    mem_req_len,
	input logic [`MEM_DATA_NBITS-1:0]   mem_req_data,
	input logic                         mem_req_domain,
	input logic                         insecure
);

	// Request held stable under back-pressure
	req_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_addr)
			&& $stable(mem_req_data) && $stable(mem_req_type) && $stable(mem_req_opaque)
			&& $stable(mem_req_len) && $stable(mem_req_domain))
		else $error("memory request changed before it was accepted");

	no_overlap: assert property (@(posedge clk) disable iff (reset)
		!(insecure && mem_req_val))
		else $error("insecure pulse during a memory request");

	idle_after_reset: assert property (@(posedge clk) reset |=> !mem_req_val)
		else $error("memory request valid right after reset");

endmodule

bind addr_space_ctrl mem_addr_props props0 (.*);

//--- sim/mem_addr_tb.sv
// Testbench for the memory address-space controller
// Drives cache requests, models memory and checks responses against a reference

`timescale 1ns/10ps

`include "mem_addr_consts.svh"

module mem_addr_tb
	import mem_addr_pkg::*;
;

	logic        clk;
	logic        reset;

	logic        cache_req_type = 1'b0;
	logic [7:0]  cache_req_opaque = '0;
	logic [31:0] cache_req_addr = '0;
	logic [1:0]  cache_req_len = '0;
	logic [31:0] cache_req_data = '0;
	logic        req_sec_level = 1'b0;
	logic        cache_req_val = 1'b0;
	logic        cache_req_rdy;
	logic        mem_req_type;
	logic [7:0]  mem_req_opaque;
	logic [31:0] mem_req_addr;
	logic [1:0]  mem_req_len;
	logic [31:0] mem_req_data;
	logic        mem_req_domain;
	logic        mem_req_val;
	logic        mem_req_rdy = 1'b0;
	logic        mem_resp_type = 1'b0;
	logic [7:0]  mem_resp_opaque = '0;
	logic [1:0]  mem_resp_len = '0;
	logic [31:0] mem_resp_data = '0;
	logic        mem_resp_val = 1'b0;
	logic        mem_resp_rdy;
	logic        cache_resp_type;
	logic [7:0]  cache_resp_opaque;
	logic [1:0]  cache_resp_len;
	logic [31:0] cache_resp_data;
	logic        resp_sec_level;
	logic        cache_resp_val;
	logic        cache_resp_rdy = 1'b0;
	logic        insecure;

	// Scoreboard state
	mem_resp_msg_t exp_q[$];
	logic [31:0]   ref_mem [logic [31:0]];
	logic [31:0]   mem_words [logic [31:0]];
	logic [31:0]   par_track = `INITIAL_PAR;
	logic [15:0]   lfsr = 16'd99;
	logic [7:0]    next_opaque = '0;
	int            errors = 0;
	int            pulses = 0;
	int            exp_pulses = 0;
	int            issued = 0;
	int            cycles = 0;
	logic          mem_stall = 1'b0;
	logic          resp_stall = 1'b0;

	tb_clock clock0 (.clk(clk), .reset(reset));

	mem_addr_ctrl_top dut0 (.*);

	// ----------------------------------------
	// Random numbers and reference
	// ----------------------------------------

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_word(input int n);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < n; i++) begin
			w = {w[30:0], rand_bit()};
		end
		return w;
	endfunction

	function automatic mem_resp_msg_t ref_response(input logic typ, input logic [7:0] op,
			input logic [31:0] addr, input logic [1:0] len, input logic sec,
			input logic [31:0] par, output logic insec_due, output logic fwd);
		mem_resp_msg_t r;
		r.msg_type  = mem_msg_type_e'(typ);
		r.opaque    = op;
		r.len       = len;
		r.data      = '0;
		r.sec_level = sec;
		insec_due   = 1'b0;
		fwd         = 1'b0;
		if (addr >= `MEM_SIZE) begin
			insec_due = 1'b1;
		end else if (sec && typ && addr == '0) begin
			// Partition load, answered locally
		end else if (!sec && (addr == '0 || addr >= par)) begin
			insec_due = 1'b1;
		end else begin
			fwd = 1'b1;
			if (!typ) begin
				r.data = ref_mem.exists(addr >> 2) ? ref_mem[addr >> 2]
					: (addr >> 2) + 32'ha5a50000;
			end
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Memory model, one request at a time
	// ----------------------------------------

	logic busy = 1'b0;
	logic resp_taken = 1'b0;
	int   delay = 0;
	logic [31:0] pend_data;
	logic [31:0] word;

	always @(negedge clk) begin
		if (resp_taken) begin
			mem_resp_val = 1'b0;
			resp_taken = 1'b0;
		end
		if (busy && !mem_resp_val) begin
			if (delay == 0) begin
				mem_resp_data = pend_data;
				mem_resp_val = 1'b1;
			end else begin
				delay--;
			end
		end
		mem_req_rdy = mem_stall ? rand_bit() : 1'b1;
		#1;
		if (mem_req_val && mem_req_rdy) begin
			if (mem_req_addr >= `MEM_SIZE) begin
				$display("Memory received an out-of-range address %h", mem_req_addr);
				errors++;
			end
			if (mem_req_type && mem_req_domain && mem_req_addr == '0) begin
				$display("Memory received the partition write");
				errors++;
			end
			word = mem_req_addr >> 2;
			mem_resp_type = mem_req_type;
			mem_resp_opaque = mem_req_opaque;
			mem_resp_len = mem_req_len;
			if (mem_req_type) begin
				mem_words[word] = mem_req_data;
				pend_data = '0;
			end else begin
				pend_data = mem_words.exists(word) ? mem_words[word] : word + 32'ha5a50000;
			end
			delay = int'(rand_word(2));
			busy = 1'b1;
		end
		if (mem_resp_val && mem_resp_rdy) begin
			busy = 1'b0;
			resp_taken = 1'b1;
		end
	end

	// ----------------------------------------
	// Response compare
	// ----------------------------------------

	mem_resp_msg_t head;

	always @(negedge clk) begin
		if (insecure === 1'b1) begin
			pulses++;
		end
		cache_resp_rdy = resp_stall ? rand_bit() : 1'b1;
		#1;
		if (cache_resp_val && cache_resp_rdy) begin
			if (exp_q.size() == 0) begin
				$display("Cache response at %0t with no request outstanding", $time);
				errors++;
			end else begin
				head = exp_q.pop_front();
				check_val("cache_resp_type", 32'(cache_resp_type), 32'(head.msg_type));
				check_val("cache_resp_opaque", 32'(cache_resp_opaque), 32'(head.opaque));
				check_val("cache_resp_len", 32'(cache_resp_len), 32'(head.len));
				check_val("cache_resp_data", cache_resp_data, head.data);
				check_val("resp_sec_level", 32'(resp_sec_level), 32'(head.sec_level));
			end
		end
	end

	// Ends a run that stops making progress
	initial begin
		while (cycles <= 200 * (issued + 1)) begin
			@(negedge clk);
			cycles++;
		end
		$display("Timeout: no progress after %0d cycles", cycles);
		$display("*** FAILED ***");
		$finish;
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	// Called on a falling edge, returns on a falling edge
	task automatic send_req(input logic typ, input logic [31:0] addr,
			input logic [31:0] data, input logic sec);
		mem_resp_msg_t exp;
		logic due;
		logic fwd;
		logic [31:0] r;
		r = rand_word(2);
		cache_req_type = typ;
		cache_req_opaque = next_opaque;
		cache_req_addr = addr;
		cache_req_len = r[1:0];
		cache_req_data = data;
		req_sec_level = sec;
		cache_req_val = 1'b1;
		#1;
		while (!cache_req_rdy) begin
			@(negedge clk);
			#1;
		end
		exp = ref_response(typ, next_opaque, addr, r[1:0], sec, par_track, due, fwd);
		if (fwd && typ) ref_mem[addr >> 2] = data;
		if (!fwd && !due) par_track = data;
		if (due) exp_pulses++;
		exp_q.push_back(exp);
		issued++;
		next_opaque++;
		@(negedge clk);
		cache_req_val = 1'b0;
	endtask

	task automatic finish_test(input string name, input int first);
		while (exp_q.size() != 0) @(negedge clk);
		repeat (2) @(negedge clk);
		check_val("insecure pulse count", 32'(pulses), 32'(exp_pulses));
		$display("Test %s done: %0d requests, %0d errors so far", name, issued - first, errors);
	endtask

	function automatic logic [31:0] low_addr(input int bits);
		logic [31:0] a;
		a = rand_word(bits) << 2;
		return (a == '0) ? 32'd4 : a;
	endfunction

	int first;
	logic [31:0] a;

	initial begin
		@(negedge clk);
		while (reset) @(negedge clk);

		first = issued;
		for (int i = 0; i < 12; i++) begin
			send_req(rand_bit(), low_addr(14), rand_word(32), 1'b1);
		end
		finish_test("secure", first);

		first = issued;
		for (int i = 0; i < 6; i++) begin
			a = low_addr(12);
			send_req(1'b1, a, rand_word(32), 1'b0);
			send_req(1'b0, a, '0, 1'b0);
		end
		finish_test("insecure_forward", first);

		first = issued;
		send_req(1'b0, 32'd0, '0, 1'b0);
		send_req(1'b1, 32'd0, 32'h1234, 1'b0);
		for (int i = 0; i < 6; i++) begin
			send_req(rand_bit(), 32'hc000 + (rand_word(12) << 2), rand_word(32), 1'b0);
		end
		finish_test("insecure_deny", first);

		first = issued;
		send_req(1'b1, 32'd0, 32'h2000, 1'b1);
		send_req(1'b0, 32'h3000, '0, 1'b0);
		send_req(1'b0, 32'h1000, '0, 1'b0);
		send_req(1'b1, 32'd0, 32'h8000, 1'b1);
		send_req(1'b1, 32'h3000, 32'hbeef, 1'b0);
		send_req(1'b0, 32'h3000, '0, 1'b0);
		finish_test("partition", first);

		first = issued;
		send_req(1'b0, 32'h10000, '0, 1'b1);
		send_req(1'b1, 32'hfffffffc, 32'h55, 1'b1);
		send_req(1'b0, 32'h20000, '0, 1'b0);
		send_req(1'b1, 32'h10004, 32'h66, 1'b0);
		finish_test("out_of_range", first);

		first = issued;
		mem_stall = 1'b1;
		resp_stall = 1'b1;
		for (int i = 0; i < 40; i++) begin
			send_req(rand_bit(), low_addr(15), rand_word(32), rand_bit());
			if (rand_bit()) @(negedge clk);
		end
		finish_test("stress", first);

		$display("Done: %0d requests, %0d pulses, %0d errors", issued, pulses, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+logic
logic/mem_addr_pkg.sv
logic/msg_hold_reg.sv
logic/cache_req_in.sv
logic/addr_space_ctrl.sv
logic/resp_merge.sv
logic/mem_addr_ctrl_top.sv
sim/tb_clock.sv
sim/mem_addr_props.sv
sim/mem_addr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module mem_addr_tb -o Vmem_addr_tb
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

out=$(./obj_dir/Vmem_addr_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
